// ==== common/sd_cmd_pkg.sv ====
package sd_cmd_pkg;

    // ========================================================================
    // command side
    // ========================================================================

    // command index as carried in the frame
    typedef logic [5:0] cmd_index_t;

    // command argument
    typedef logic [31:0] cmd_arg_t;

    // what the card is expected to send back
    typedef enum logic [1:0] {
        RESP_NONE  = 2'd0,
        RESP_SHORT = 2'd1,
        RESP_LONG  = 2'd2
    } resp_kind_t;

    // ========================================================================
    // response side
    // ========================================================================

    // 48-bit response, msb first on the line
    // raw view for shifting, field view for checking
    typedef union packed {
        logic [47:0] raw;
        struct packed {
            logic        start_bit;
            logic        trans_bit;
            logic [5:0]  index;
            logic [31:0] status;
            logic [6:0]  crc;
            logic        end_bit;
        } f;
    } short_resp_t;

    // 136-bit response, kept as captured incl. start and end bits
    typedef logic [135:0] long_resp_t;

endpackage

// ==== common/sd_line_pkg.sv ====
package sd_line_pkg;

    // ========================================================================
    // frame lengths on the command line
    // ========================================================================

    // start + trans + index + arg + crc7 + end
    localparam int unsigned CMD_FRAME_BITS = 48;

    // R1/R6/R7 style
    localparam int unsigned SHORT_RESP_BITS = 48;

    // R2 style, cid / csd
    localparam int unsigned LONG_RESP_BITS = 136;

    // ========================================================================
    // controller sequencing
    // ========================================================================

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        // frame going out
        ST_SEND      = 3'd1,
        // waiting for the card start bit
        ST_WAIT_RESP = 3'd2,
        // response bits coming in
        ST_RECV      = 3'd3,
        // one cycle, cmd_done
        ST_FINISH    = 3'd4
    } ctrl_state_t;

endpackage

// ==== hw/sd_clk_gen.sv ====
`timescale 1ns/1ns

module sd_clk_gen #(
    parameter int CLK_DIV = 4
) (
    input  logic clk,
    input  logic rst_n,
    output logic sd_clk,
    output logic drive_tick,
    output logic sample_tick
);

    // clk cycles per sd_clk half period
    localparam int HALF  = CLK_DIV / 2;
    localparam int CNT_W = (HALF > 1) ? $clog2(HALF) : 1;

    logic [CNT_W-1:0] cnt;
    logic             edge_now;

    // last cycle of the half period
    assign edge_now = (cnt == CNT_W'(HALF - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt         <= '0;
            sd_clk      <= 1'b0;
            drive_tick  <= 1'b0;
            sample_tick <= 1'b0;
        end else begin
            drive_tick  <= 1'b0;
            sample_tick <= 1'b0;
            if (edge_now) begin
                cnt    <= '0;
                sd_clk <= ~sd_clk;
                // high -> low, host may change the line
                drive_tick  <= sd_clk;
                // low -> high, line is stable
                sample_tick <= ~sd_clk;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hw/crc7_gen.sv ====
`timescale 1ns/1ns

module crc7_gen (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       shift,
    input  logic       din,
    output logic [6:0] crc
);

    // feedback of x^7, folded in at x^3 and x^0
    logic       fb;
    logic [6:0] crc_next;

    assign fb       = din ^ crc[6];
    assign crc_next = {crc[5:3], crc[2] ^ fb, crc[1:0], fb};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crc <= '0;
        end else if (clear) begin
            // new frame
            crc <= '0;
        end else if (shift) begin
            crc <= crc_next;
        end
    end

endmodule

// ==== sd_cmd/sd_cmd_tx.sv ====
`timescale 1ns/1ns

module sd_cmd_tx
    import sd_cmd_pkg::*;
    import sd_line_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       drive_tick,
    input  logic       tx_start,
    input  cmd_index_t cmd_index,
    input  cmd_arg_t   cmd_arg,
    output logic       tx_done,
    output logic       sd_cmd_o,
    output logic       sd_cmd_oe
);

    // bits ahead of the crc: start, trans, index, arg
    localparam int PAYLOAD_BITS = CMD_FRAME_BITS - 8;
    localparam int CNT_W        = $clog2(CMD_FRAME_BITS + 1);

    logic [PAYLOAD_BITS-1:0] shifter;
    logic [CNT_W-1:0]        bit_cnt;
    logic                    armed;
    logic                    at_crc;
    logic                    frame_end;
    logic                    tx_bit;
    logic                    crc_shift;
    logic [6:0]              crc;

    // ========================================================================
    // bit position decode
    // ========================================================================

    // first crc bit comes straight from the crc register
    assign at_crc    = (bit_cnt == CNT_W'(PAYLOAD_BITS));
    assign frame_end = (bit_cnt == CNT_W'(CMD_FRAME_BITS));
    assign tx_bit    = at_crc ? crc[6] : shifter[PAYLOAD_BITS-1];

    // falling edge after the end bit
    assign tx_done   = drive_tick & armed & frame_end;

    // crc only sees the payload bits
    assign crc_shift = drive_tick & armed & (bit_cnt < CNT_W'(PAYLOAD_BITS));

    crc7_gen u_crc7 (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (tx_start),
        .shift (crc_shift),
        .din   (shifter[PAYLOAD_BITS-1]),
        .crc   (crc)
    );

    // ========================================================================
    // line drive
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            armed     <= 1'b0;
            bit_cnt   <= '0;
            sd_cmd_o  <= 1'b1;
            sd_cmd_oe <= 1'b0;
        end else if (tx_start) begin
            // wait for next falling edge
            armed   <= 1'b1;
            bit_cnt <= '0;
        end else if (drive_tick && armed) begin
            if (frame_end) begin
                armed     <= 1'b0;
                sd_cmd_oe <= 1'b0;
                sd_cmd_o  <= 1'b1;
            end else begin
                sd_cmd_oe <= 1'b1;
                sd_cmd_o  <= tx_bit;
                bit_cnt   <= bit_cnt + 1'b1;
            end
        end
    end

    // payload shifter, refilled with crc tail + end bit
    always_ff @(posedge clk) begin
        if (tx_start) begin
            shifter <= {1'b0, 1'b1, cmd_index, cmd_arg};
        end else if (drive_tick && armed) begin
            if (at_crc) begin
                shifter <= {crc[5:0], 1'b1, {(PAYLOAD_BITS - 7){1'b0}}};
            end else begin
                shifter <= {shifter[PAYLOAD_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== sd_cmd/sd_cmd_rx.sv ====
`timescale 1ns/1ns

module sd_cmd_rx
    import sd_cmd_pkg::*;
    import sd_line_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sample_tick,
    input  logic        rx_start,
    input  logic        rx_long,
    input  logic        sd_cmd_i,
    output logic        rx_started,
    output logic        rx_done,
    output short_resp_t resp_short,
    output long_resp_t  resp_long,
    output logic        crc_err
);

    // crc covers start, trans, index, status
    localparam int CRC_BITS = SHORT_RESP_BITS - 8;
    localparam int CNT_W    = $clog2(LONG_RESP_BITS);

    logic             armed;
    logic             receiving;
    logic             long_mode;
    logic [CNT_W-1:0] bit_cnt;
    logic [CNT_W-1:0] last_idx;
    logic             take_bit;
    logic             crc_shift;
    logic [6:0]       crc;
    short_resp_t      short_q;
    short_resp_t      short_next;
    long_resp_t       long_q;

    // ========================================================================
    // bit acceptance
    // ========================================================================

    assign last_idx = long_mode ? CNT_W'(LONG_RESP_BITS - 1) : CNT_W'(SHORT_RESP_BITS - 1);

    // first low sample while armed is the start bit
    assign rx_started = sample_tick & armed & ~sd_cmd_i;
    assign rx_done    = sample_tick & receiving & (bit_cnt == last_idx);
    assign take_bit   = rx_started | (sample_tick & receiving);

    // start bit counts as bit 0 of the crc
    assign crc_shift  = rx_started |
                        (sample_tick & receiving & (bit_cnt < CNT_W'(CRC_BITS)));

    // word as it will be once the current bit is in
    assign short_next.raw = {short_q.raw[SHORT_RESP_BITS-2:0], sd_cmd_i};

    crc7_gen u_crc7 (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (rx_start),
        .shift (crc_shift),
        .din   (sd_cmd_i),
        .crc   (crc)
    );

    // ========================================================================
    // control
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            armed     <= 1'b0;
            receiving <= 1'b0;
            long_mode <= 1'b0;
            bit_cnt   <= '0;
            crc_err   <= 1'b0;
        end else if (rx_start) begin
            // rearm drops any capture still running
            armed     <= 1'b1;
            receiving <= 1'b0;
            long_mode <= rx_long;
            crc_err   <= 1'b0;
        end else if (rx_started) begin
            armed     <= 1'b0;
            receiving <= 1'b1;
            bit_cnt   <= CNT_W'(1);
        end else if (rx_done) begin
            receiving <= 1'b0;
            // bad crc field or missing end bit, short only
            crc_err   <= ~long_mode &
                         ((short_next.f.crc != crc) | ~short_next.f.end_bit);
        end else if (sample_tick && receiving) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // ========================================================================
    // capture, msb first
    // ========================================================================

    always_ff @(posedge clk) begin
        if (take_bit) begin
            short_q <= short_next;
            long_q  <= {long_q[LONG_RESP_BITS-2:0], sd_cmd_i};
        end
    end

    assign resp_short = short_q;
    assign resp_long  = long_q;

endmodule

// ==== hw/sd_cmd_ctrl.sv ====
`timescale 1ns/1ns

module sd_cmd_ctrl
    import sd_cmd_pkg::*;
    import sd_line_pkg::*;
#(
    parameter int RESP_TIMEOUT = 64
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       drive_tick,
    input  logic       cmd_start,
    input  cmd_index_t cmd_index,
    input  logic       tx_done,
    input  logic       rx_started,
    input  logic       rx_done,
    output logic       tx_start,
    output logic       rx_start,
    output logic       rx_long,
    output logic       busy,
    output logic       cmd_done,
    output logic       resp_timeout
);

    localparam int TMR_W = (RESP_TIMEOUT > 1) ? $clog2(RESP_TIMEOUT) : 1;

    ctrl_state_t      state;
    resp_kind_t       kind_q;
    logic [TMR_W-1:0] timer;

    // cmd0 silent, cid/csd long, rest short
    function automatic resp_kind_t kind_of(input cmd_index_t idx);
        resp_kind_t k;
        case (idx)
            6'd0:                k = RESP_NONE;
            6'd2, 6'd9, 6'd10:   k = RESP_LONG;
            default:             k = RESP_SHORT;
        endcase
        return k;
    endfunction

    // ========================================================================
    // strobes to tx / rx
    // ========================================================================

    // tx latches index and arg in the accept cycle
    assign tx_start = cmd_start & (state == ST_IDLE);

    // rx armed for every command so its crc flag never goes stale
    assign rx_start = tx_done & (state == ST_SEND);
    assign rx_long  = (kind_q == RESP_LONG);

    // busy already low in the done cycle
    assign busy     = (state != ST_IDLE) & (state != ST_FINISH);
    assign cmd_done = (state == ST_FINISH);

    // ========================================================================
    // sequencing
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            kind_q       <= RESP_NONE;
            timer        <= '0;
            resp_timeout <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_start) begin
                        state        <= ST_SEND;
                        kind_q       <= kind_of(cmd_index);
                        resp_timeout <= 1'b0;
                    end
                end
                ST_SEND: begin
                    if (tx_done) begin
                        timer <= '0;
                        state <= (kind_q == RESP_NONE) ? ST_FINISH : ST_WAIT_RESP;
                    end
                end
                ST_WAIT_RESP: begin
                    // timeout counted in sd_clk periods
                    if (rx_started) begin
                        state <= ST_RECV;
                    end else if (drive_tick) begin
                        if (timer == TMR_W'(RESP_TIMEOUT - 1)) begin
                            resp_timeout <= 1'b1;
                            state        <= ST_FINISH;
                        end else begin
                            timer <= timer + 1'b1;
                        end
                    end
                end
                ST_RECV: begin
                    if (rx_done) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/sd_host_top.sv ====
`timescale 1ns/1ns

module sd_host_top
    import sd_cmd_pkg::*;
#(
    parameter int CLK_DIV      = 4,
    parameter int RESP_TIMEOUT = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  cmd_index_t  cmd_index,
    input  cmd_arg_t    cmd_arg,
    input  logic        cmd_start,
    output logic        busy,
    output logic        cmd_done,
    output short_resp_t resp_short,
    output long_resp_t  resp_long,
    output logic        resp_timeout,
    output logic        resp_crc_err,
    output logic        sd_clk,
    output logic        sd_cmd_o,
    output logic        sd_cmd_oe,
    input  logic        sd_cmd_i
);

    // sd_clk edge strobes
    logic drive_tick;
    logic sample_tick;

    // ctrl <-> tx / rx
    logic tx_start;
    logic tx_done;
    logic rx_start;
    logic rx_long;
    logic rx_started;
    logic rx_done;

    sd_clk_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_clk_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .sd_clk      (sd_clk),
        .drive_tick  (drive_tick),
        .sample_tick (sample_tick)
    );

    sd_cmd_ctrl #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .drive_tick   (drive_tick),
        .cmd_start    (cmd_start),
        .cmd_index    (cmd_index),
        .tx_done      (tx_done),
        .rx_started   (rx_started),
        .rx_done      (rx_done),
        .tx_start     (tx_start),
        .rx_start     (rx_start),
        .rx_long      (rx_long),
        .busy         (busy),
        .cmd_done     (cmd_done),
        .resp_timeout (resp_timeout)
    );

    sd_cmd_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .drive_tick (drive_tick),
        .tx_start   (tx_start),
        .cmd_index  (cmd_index),
        .cmd_arg    (cmd_arg),
        .tx_done    (tx_done),
        .sd_cmd_o   (sd_cmd_o),
        .sd_cmd_oe  (sd_cmd_oe)
    );

    sd_cmd_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_tick (sample_tick),
        .rx_start    (rx_start),
        .rx_long     (rx_long),
        .sd_cmd_i    (sd_cmd_i),
        .rx_started  (rx_started),
        .rx_done     (rx_done),
        .resp_short  (resp_short),
        .resp_long   (resp_long),
        .crc_err     (resp_crc_err)
    );

endmodule

// ==== testbench/sd_card_model.sv ====
`timescale 1ns/1ns

module sd_card_model
    import sd_cmd_pkg::*;
(
    input  logic        sd_clk,
    input  logic        sd_cmd_o,
    input  logic        sd_cmd_oe,
    input  logic [1:0]  mode,
    input  long_resp_t  resp_data,
    output logic        sd_cmd_i,
    output logic [47:0] frame_q,
    output logic        frame_crc_ok,
    output logic        frame_fmt_ok,
    output logic [6:0]  sent_crc,
    output int          frame_count,
    output int          oe_len,
    output int          answer_count
);

    localparam logic [1:0] MODE_CORRUPT = 2'd1;
    localparam logic [1:0] MODE_SILENT  = 2'd2;

    logic [47:0] shift_q;
    int          run_len;
    logic        card_oe;
    logic        card_bit;
    cmd_index_t  rx_index;
    short_resp_t short_w;
    long_resp_t  ans_word;
    int          ans_len;
    int          i;
    event        got_frame;

    // crc7, x^7 + x^3 + 1, msb first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        int         n;
        c = '0;
        for (n = 39; n >= 0; n--) begin
            fb = bits[n] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    // shared line, pulled up when idle
    assign sd_cmd_i = sd_cmd_oe ? sd_cmd_o : (card_oe ? card_bit : 1'b1);

    initial begin
        shift_q      = '0;
        run_len      = 0;
        card_oe      = 1'b0;
        card_bit     = 1'b1;
        frame_q      = '0;
        frame_crc_ok = 1'b0;
        frame_fmt_ok = 1'b0;
        sent_crc     = '0;
        frame_count  = 0;
        oe_len       = 0;
        answer_count = 0;
    end

    // ========================================================================
    // host frame capture on rising sd_clk
    // ========================================================================

    always @(posedge sd_clk) begin
        if (sd_cmd_oe) begin
            shift_q = {shift_q[46:0], sd_cmd_o};
            run_len = run_len + 1;
            if (run_len == 48) begin
                frame_q      = shift_q;
                frame_crc_ok = (crc7_of(shift_q[47:8]) == shift_q[7:1]);
                // start 0, transmission 1, end 1
                frame_fmt_ok = ~shift_q[47] & shift_q[46] & shift_q[0];
                frame_count  = frame_count + 1;
                -> got_frame;
            end
        end else if (run_len != 0) begin
            // host released the line
            oe_len  = run_len;
            run_len = 0;
        end
    end

    // ========================================================================
    // response, driven after falling sd_clk
    // ========================================================================

    always begin
        @(got_frame);
        rx_index = frame_q[45:40];
        // cmd0 never gets an answer
        if (rx_index != 6'd0 && mode != MODE_SILENT) begin
            if (rx_index == 6'd2 || rx_index == 6'd9 || rx_index == 6'd10) begin
                ans_word = resp_data;
                ans_len  = 136;
            end else begin
                short_w.f.start_bit = 1'b0;
                short_w.f.trans_bit = 1'b0;
                short_w.f.index     = rx_index;
                short_w.f.status    = resp_data[31:0];
                short_w.f.crc       = crc7_of(short_w.raw[47:8]);
                if (mode == MODE_CORRUPT) begin
                    short_w.f.crc = short_w.f.crc ^ 7'h01;
                end
                short_w.f.end_bit = 1'b1;
                sent_crc          = short_w.f.crc;
                ans_word          = {88'b0, short_w.raw};
                ans_len           = 48;
            end
            // end of the end bit, then two idle periods
            repeat (3) @(negedge sd_clk);
            for (i = ans_len - 1; i >= 0; i--) begin
                #1;
                card_oe  = 1'b1;
                card_bit = ans_word[i];
                @(negedge sd_clk);
            end
            #1;
            card_oe      = 1'b0;
            card_bit     = 1'b1;
            answer_count = answer_count + 1;
        end
    end

endmodule

// ==== testbench/tb_sd_host.sv ====
`timescale 1ns/1ns

module tb_sd_host
    import sd_cmd_pkg::*;
();

    localparam int         CLK_DIV      = 4;
    localparam int         RESP_TIMEOUT = 64;
    localparam int         MAX_CMDS     = 64;
    localparam string      STIM_FILE    = "testbench/sd_cmd_stim.txt";
    localparam logic [1:0] MODE_SILENT  = 2'd2;

    logic        clk;
    logic        rst_n;
    cmd_index_t  cmd_index;
    cmd_arg_t    cmd_arg;
    logic        cmd_start;
    logic        busy;
    logic        cmd_done;
    short_resp_t resp_short;
    long_resp_t  resp_long;
    logic        resp_timeout;
    logic        resp_crc_err;
    logic        sd_clk;
    logic        sd_cmd_o;
    logic        sd_cmd_oe;
    logic        sd_cmd_i;

    // card model side
    logic [1:0]  card_mode;
    long_resp_t  card_data;
    logic [47:0] frame_q;
    logic        frame_crc_ok;
    logic        frame_fmt_ok;
    logic [6:0]  sent_crc;
    int          frame_count;
    int          oe_len;
    int          answer_count;

    // stim table, one entry per command
    cmd_index_t  st_index [MAX_CMDS];
    cmd_arg_t    st_arg   [MAX_CMDS];
    logic [1:0]  st_mode  [MAX_CMDS];
    long_resp_t  st_data  [MAX_CMDS];
    bit          st_to    [MAX_CMDS];
    bit          st_crc   [MAX_CMDS];
    bit          st_dup   [MAX_CMDS];
    int          n_cmds      = 0;
    int          done_count  = 0;
    int          exp_done    = 0;
    int          exp_answers = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    sd_host_top #(
        .CLK_DIV      (CLK_DIV),
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_index    (cmd_index),
        .cmd_arg      (cmd_arg),
        .cmd_start    (cmd_start),
        .busy         (busy),
        .cmd_done     (cmd_done),
        .resp_short   (resp_short),
        .resp_long    (resp_long),
        .resp_timeout (resp_timeout),
        .resp_crc_err (resp_crc_err),
        .sd_clk       (sd_clk),
        .sd_cmd_o     (sd_cmd_o),
        .sd_cmd_oe    (sd_cmd_oe),
        .sd_cmd_i     (sd_cmd_i)
    );

    sd_card_model u_card (
        .sd_clk       (sd_clk),
        .sd_cmd_o     (sd_cmd_o),
        .sd_cmd_oe    (sd_cmd_oe),
        .mode         (card_mode),
        .resp_data    (card_data),
        .sd_cmd_i     (sd_cmd_i),
        .frame_q      (frame_q),
        .frame_crc_ok (frame_crc_ok),
        .frame_fmt_ok (frame_fmt_ok),
        .sent_crc     (sent_crc),
        .frame_count  (frame_count),
        .oe_len       (oe_len),
        .answer_count (answer_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit, armed once the stim length is known
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("simulation timed out waiting for cmd_done");
            $display("TEST FAIL");
            $fatal(1, "run stopped");
        end
    end

    // every done pulse, wanted or not
    always @(posedge clk) begin
        if (rst_n && cmd_done) begin
            done_count <= done_count + 1;
        end
    end

    // ========================================================================
    // checks
    // ========================================================================

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_short(input string name, input short_resp_t exp, input short_resp_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                                    $time, name, exp.raw, act.raw));
        end
    endtask

    task automatic check_long(input string name, input long_resp_t exp, input long_resp_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH at %0t: %s expected %b actual %b",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_frame(input cmd_index_t exp_idx, input cmd_arg_t exp_arg,
                               input cmd_index_t act_idx, input cmd_arg_t act_arg);
        if (act_idx !== exp_idx || act_arg !== exp_arg) begin
            stop_on_error($sformatf("MISMATCH at %0t: frame expected %h/%h actual %h/%h",
                                    $time, exp_idx, exp_arg, act_idx, act_arg));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_on_error($sformatf("MISMATCH at %0t: %s expected %0d actual %0d",
                                    $time, name, exp, act));
        end
    endtask

    // cid / csd reads
    function automatic bit is_long_index(input cmd_index_t idx);
        return (idx == 6'd2) || (idx == 6'd9) || (idx == 6'd10);
    endfunction

    // ========================================================================
    // stimulus
    // ========================================================================

    task automatic load_stim();
        int          fd;
        int          got;
        string       line;
        logic [31:0] t_idx;
        logic [31:0] t_arg;
        logic [31:0] t_mode;
        logic [31:0] t_to;
        logic [31:0] t_crc;
        logic [31:0] t_dup;
        long_resp_t  t_data;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stop_on_error("could not open the stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            // skip comments and blank lines
            if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%h %h %d %h %d %d %d",
                              t_idx, t_arg, t_mode, t_data, t_to, t_crc, t_dup);
                if (got != 7 || n_cmds >= MAX_CMDS) begin
                    stop_on_error("stimulus file has a bad or extra line");
                end
                st_index[n_cmds] = t_idx[5:0];
                st_arg[n_cmds]   = t_arg;
                st_mode[n_cmds]  = t_mode[1:0];
                st_data[n_cmds]  = t_data;
                st_to[n_cmds]    = t_to[0];
                st_crc[n_cmds]   = t_crc[0];
                st_dup[n_cmds]   = t_dup[0];
                n_cmds           = n_cmds + 1;
            end
        end
        $fclose(fd);
    endtask

    // one command, entered and left 1 ns after a rising edge
    task automatic run_command(input int k);
        short_resp_t exp_s;
        card_mode = st_mode[k];
        card_data = st_data[k];
        cmd_index = st_index[k];
        cmd_arg   = st_arg[k];
        cmd_start = 1'b1;
        @(posedge clk);
        #1;
        cmd_start = 1'b0;
        check_flag("busy", 1'b1, busy);
        if (st_dup[k]) begin
            // second start mid-frame with other values, must be dropped
            repeat (30) @(posedge clk);
            #1;
            cmd_index = st_index[k] ^ 6'h01;
            cmd_arg   = ~st_arg[k];
            cmd_start = 1'b1;
            @(posedge clk);
            #1;
            cmd_start = 1'b0;
            cmd_index = st_index[k];
            cmd_arg   = st_arg[k];
            check_flag("busy", 1'b1, busy);
        end
        @(posedge clk);
        while (cmd_done !== 1'b1) begin
            @(posedge clk);
        end
        check_flag("busy", 1'b0, busy);
        check_flag("resp_timeout", st_to[k], resp_timeout);
        check_flag("resp_crc_err", st_crc[k], resp_crc_err);
        if (st_index[k] != 6'd0 && st_mode[k] != MODE_SILENT) begin
            exp_answers = exp_answers + 1;
            if (is_long_index(st_index[k])) begin
                check_long("resp_long", st_data[k], resp_long);
            end else begin
                exp_s.f.start_bit = 1'b0;
                exp_s.f.trans_bit = 1'b0;
                exp_s.f.index     = st_index[k];
                exp_s.f.status    = st_data[k][31:0];
                exp_s.f.crc       = sent_crc;
                exp_s.f.end_bit   = 1'b1;
                check_short("resp_short", exp_s, resp_short);
            end
        end
        exp_done = exp_done + 1;
        // done is a single cycle
        @(posedge clk);
        check_flag("cmd_done", 1'b0, cmd_done);
        // let the card finish and release the line
        repeat (12) @(posedge clk);
        #1;
        check_frame(st_index[k], st_arg[k], frame_q[45:40], frame_q[39:8]);
        check_flag("frame crc7", 1'b1, frame_crc_ok);
        check_flag("frame start/trans/end bits", 1'b1, frame_fmt_ok);
        check_count("sd_cmd_oe periods", 48, oe_len);
        check_count("frames seen by card", k + 1, frame_count);
        check_count("cmd_done pulses", exp_done, done_count);
        check_count("card answers", exp_answers, answer_count);
    endtask

    initial begin
        int k;
        rst_n     = 1'b0;
        cmd_index = '0;
        cmd_arg   = '0;
        cmd_start = 1'b0;
        card_mode = MODE_SILENT;
        card_data = '0;
        load_stim();
        cycle_limit = n_cmds * (RESP_TIMEOUT + 200) * CLK_DIV;
        repeat (8) @(posedge clk);
        #1;
        // outputs held in reset
        check_flag("sd_clk", 1'b0, sd_clk);
        check_flag("sd_cmd_oe", 1'b0, sd_cmd_oe);
        check_flag("sd_cmd_o", 1'b1, sd_cmd_o);
        check_flag("busy", 1'b0, busy);
        check_flag("cmd_done", 1'b0, cmd_done);
        check_flag("resp_timeout", 1'b0, resp_timeout);
        check_flag("resp_crc_err", 1'b0, resp_crc_err);
        rst_n = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        for (k = 0; k < n_cmds; k++) begin
            run_command(k);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== testbench/sd_cmd_stim.txt ====
# index arg mode data timeout crc_err dup   (hex, hex, dec, hex, dec, dec, dec)
# mode 0 answer, 1 corrupt crc, 2 silent; data is card status or 136-bit long word
00 00000000 0 0                                  0 0 0
08 000001aa 0 000001aa                           0 0 0
37 00000000 0 00000120                           0 0 0
29 40ff8000 0 80ff8000                           0 0 0
02 00000000 0 3f035344534430318012345678009a4b01 0 0 0
03 00000000 0 aaaa0500                           0 0 0
09 aaaa0000 0 3f400e00325b5900003b377f800a4040af 0 0 0
0a aaaa0000 0 3fa5a5a5a55a5a5a5a0123456789abcdef 0 0 1
07 aaaa0000 1 00000700                           0 1 0
0d aaaa0000 2 00000000                           1 0 0
02 00000000 2 3f035344534430318012345678009a4b01 1 0 0
10 00000200 0 00000900                           0 0 1
11 12345678 1 00000900                           0 1 1
00 00000000 0 0                                  0 0 1
3f ffffffff 0 deadbeef                           0 0 0
0d aaaa0000 0 00000900                           0 0 0

// ==== files.f ====
common/sd_cmd_pkg.sv
common/sd_line_pkg.sv
hw/sd_clk_gen.sv
hw/crc7_gen.sv
sd_cmd/sd_cmd_tx.sv
sd_cmd/sd_cmd_rx.sv
hw/sd_cmd_ctrl.sv
hw/sd_host_top.sv
testbench/sd_card_model.sv
testbench/tb_sd_host.sv
